// ==== mips_pkg.sv ====
package mips_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_W     = 5;
    localparam int IM_ADDR_W = 6;   // 64 instruction words
    localparam int IMM_W     = 16;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_W-1:0]     reg_addr_t;
    typedef logic [IM_ADDR_W-1:0] im_addr_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b,
        OP_HALT    = 6'h3f
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        DBG_LOAD,
        DBG_RUN,
        DBG_HALTED
    } dbg_state_t;

endpackage

// ==== reg_file.sv ====
module reg_file (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_we,
    input  mips_pkg::reg_addr_t i_waddr,
    input  mips_pkg::word_t     i_wdata,
    input  mips_pkg::reg_addr_t i_raddr_a,
    input  mips_pkg::reg_addr_t i_raddr_b,
    output mips_pkg::word_t     o_rdata_a,
    output mips_pkg::word_t     o_rdata_b,
    input  mips_pkg::reg_addr_t i_dbg_raddr,
    output mips_pkg::word_t     o_dbg_rdata
);
    import mips_pkg::*;

    word_t regs [2**REG_W];
    logic  wr_en;

    assign wr_en       = i_we && (i_waddr != '0);  // r0 stays zero
    assign o_dbg_rdata = regs[i_dbg_raddr];

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(reg_addr_t addr);
        return (wr_en && addr == i_waddr) ? i_wdata : regs[addr];
    endfunction

    always_comb begin
        o_rdata_a = read_port(i_raddr_a);
        o_rdata_b = read_port(i_raddr_b);
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

// ==== debug_ctrl.sv ====
module debug_ctrl (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_load_req,
    output logic o_load_ack,
    input  logic i_start,
    input  logic i_rd_req,
    output logic o_rd_ack,
    input  logic i_wb_halt,
    output logic o_halt,
    output logic o_run,
    output logic o_im_we
);
    import mips_pkg::*;

    dbg_state_t state;
    logic       idle;

    // No transfer in progress on either port
    assign idle    = !i_load_req && !o_load_ack && !i_rd_req && !o_rd_ack;
    assign o_im_we = (state == DBG_LOAD) && i_load_req && !o_load_ack;
    assign o_run   = (state == DBG_RUN);
    assign o_halt  = (state == DBG_HALTED);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= DBG_LOAD;
            o_load_ack <= 1'b0;
            o_rd_ack   <= 1'b0;
        end else begin
            if (o_im_we) begin
                o_load_ack <= 1'b1;
            end else if (!i_load_req) begin
                o_load_ack <= 1'b0;
            end

            if (i_rd_req && !o_rd_ack && state != DBG_RUN) begin
                o_rd_ack <= 1'b1;
            end else if (!i_rd_req) begin
                o_rd_ack <= 1'b0;
            end

            case (state)
                DBG_LOAD: if (i_start && idle) state <= DBG_RUN;
                DBG_RUN:  if (i_wb_halt) state <= DBG_HALTED;
                default:  state <= state;  // Halted until reset
            endcase
        end
    end

    a_no_ack_in_run: assert property (@(posedge i_clock) disable iff (i_reset)
        state == DBG_RUN |-> !o_load_ack && !o_rd_ack);

    a_load_ack_fall: assert property (@(posedge i_clock) disable iff (i_reset)
        $fell(o_load_ack) |-> !$past(i_load_req));

    a_rd_ack_fall: assert property (@(posedge i_clock) disable iff (i_reset)
        $fell(o_rd_ack) |-> !$past(i_rd_req));

endmodule

// ==== fetch_stage.sv ====
module fetch_stage (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_run,
    input  logic               i_stall,
    input  logic               i_im_we,
    input  mips_pkg::im_addr_t i_im_waddr,
    input  mips_pkg::word_t    i_im_wdata,
    output mips_pkg::word_t    o_instr
);
    import mips_pkg::*;

    word_t    imem [2**IM_ADDR_W];
    im_addr_t pc;  // Word address

    always_ff @(posedge i_clock) begin
        if (i_im_we) begin
            imem[i_im_waddr] <= i_im_wdata;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc      <= '0;
            o_instr <= '0;  // Zero word decodes as no-op
        end else if (i_run && !i_stall) begin
            pc      <= pc + 1'b1;
            o_instr <= imem[pc];
        end
    end

    // Program is loaded only while the pipeline is held
    a_no_load_while_running: assert property (@(posedge i_clock) disable iff (i_reset)
        i_im_we |-> !i_run);

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_run,
    input  mips_pkg::word_t     i_instr,
    input  logic                i_wb_we,
    input  mips_pkg::reg_addr_t i_wb_reg,
    input  mips_pkg::word_t     i_wb_data,
    input  mips_pkg::reg_addr_t i_dbg_raddr,
    output mips_pkg::word_t     o_dbg_rdata,
    output logic                o_stall,
    output mips_pkg::alu_op_t   o_ex_alu_op,
    output mips_pkg::word_t     o_ex_a,
    output mips_pkg::word_t     o_ex_b,
    output mips_pkg::word_t     o_ex_imm,
    output logic                o_ex_use_imm,
    output mips_pkg::reg_addr_t o_ex_rs,
    output mips_pkg::reg_addr_t o_ex_rt,
    output mips_pkg::reg_addr_t o_ex_dest,
    output logic                o_ex_reg_write,
    output logic                o_ex_mem_read,
    output logic                o_ex_mem_write,
    output logic                o_ex_halt
);
    import mips_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs, rt, rd;
    imm_t      imm;
    word_t     imm_ext, rdata_a, rdata_b;
    alu_op_t   alu_op;
    logic      use_imm, sign_ext, dest_rt, reg_write, mem_read, mem_write, is_halt;
    logic      load_use, bubble;
    logic      halt_seen;  // HALT already sent to execute

    assign opcode  = opcode_t'(i_instr[31:26]);
    assign funct   = funct_t'(i_instr[5:0]);
    assign rs      = i_instr[25:21];
    assign rt      = i_instr[20:16];
    assign rd      = i_instr[15:11];
    assign imm     = i_instr[15:0];
    assign imm_ext = sign_ext ? {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm}
                              : {{(WORD_W-IMM_W){1'b0}}, imm};

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b1;
        sign_ext  = 1'b1;
        dest_rt   = 1'b1;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_halt   = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_imm   = 1'b0;
                dest_rt   = 1'b0;
                reg_write = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;  // Unknown funct
                endcase
            end
            OP_ADDI: reg_write = 1'b1;
            OP_ANDI, OP_ORI: begin
                alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW:   mem_write = 1'b1;
            OP_HALT: is_halt = 1'b1;
            default: ;  // Unknown opcode writes nothing
        endcase
    end

    // Loaded value is not ready until MEM/WB
    assign load_use = o_ex_mem_read && (o_ex_dest != '0) &&
                      (o_ex_dest == rs || o_ex_dest == rt);
    assign bubble   = load_use || halt_seen;
    assign o_stall  = bubble || is_halt;

    reg_file u_reg_file (
        .i_clock, .i_reset,
        .i_we(i_wb_we), .i_waddr(i_wb_reg), .i_wdata(i_wb_data),
        .i_raddr_a(rs), .i_raddr_b(rt), .o_rdata_a(rdata_a), .o_rdata_b(rdata_b),
        .i_dbg_raddr, .o_dbg_rdata
    );

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_ex_reg_write <= 1'b0;
            o_ex_mem_read  <= 1'b0;
            o_ex_mem_write <= 1'b0;
            o_ex_halt      <= 1'b0;
            halt_seen      <= 1'b0;
        end else if (i_run) begin
            o_ex_reg_write <= reg_write && !bubble;
            o_ex_mem_read  <= mem_read && !bubble;
            o_ex_mem_write <= mem_write && !bubble;
            o_ex_halt      <= is_halt && !bubble;
            halt_seen      <= halt_seen || (is_halt && !load_use);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_ex_alu_op  <= alu_op;
            o_ex_a       <= rdata_a;
            o_ex_b       <= rdata_b;
            o_ex_imm     <= imm_ext;
            o_ex_use_imm <= use_imm;
            o_ex_rs      <= rs;
            o_ex_rt      <= rt;
            o_ex_dest    <= dest_rt ? rt : rd;
        end
    end

endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_run,
    input  mips_pkg::alu_op_t   i_ex_alu_op,
    input  mips_pkg::word_t     i_ex_a,
    input  mips_pkg::word_t     i_ex_b,
    input  mips_pkg::word_t     i_ex_imm,
    input  logic                i_ex_use_imm,
    input  mips_pkg::reg_addr_t i_ex_rs,
    input  mips_pkg::reg_addr_t i_ex_rt,
    input  mips_pkg::reg_addr_t i_ex_dest,
    input  logic                i_ex_reg_write,
    input  logic                i_ex_mem_read,
    input  logic                i_ex_mem_write,
    input  logic                i_ex_halt,
    input  logic                i_wb_we,
    input  mips_pkg::reg_addr_t i_wb_reg,
    input  mips_pkg::word_t     i_wb_data,
    output mips_pkg::word_t     o_mem_result,
    output mips_pkg::word_t     o_mem_store_data,
    output mips_pkg::reg_addr_t o_mem_dest,
    output logic                o_mem_reg_write,
    output logic                o_mem_mem_read,
    output logic                o_mem_mem_write,
    output logic                o_mem_halt
);
    import mips_pkg::*;

    logic  mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;
    word_t op_a, op_b, alu_b, result;

    function automatic logic hit(logic we, reg_addr_t dest, reg_addr_t src);
        return we && (dest != '0) && (dest == src);
    endfunction

    assign mem_hit_a = hit(o_mem_reg_write, o_mem_dest, i_ex_rs);
    assign mem_hit_b = hit(o_mem_reg_write, o_mem_dest, i_ex_rt);
    assign wb_hit_a  = hit(i_wb_we, i_wb_reg, i_ex_rs);
    assign wb_hit_b  = hit(i_wb_we, i_wb_reg, i_ex_rt);

    // Newest value wins
    assign op_a  = mem_hit_a ? o_mem_result : (wb_hit_a ? i_wb_data : i_ex_a);
    assign op_b  = mem_hit_b ? o_mem_result : (wb_hit_b ? i_wb_data : i_ex_b);
    assign alu_b = i_ex_use_imm ? i_ex_imm : op_b;

    always_comb begin
        case (i_ex_alu_op)
            ALU_ADD: result = op_a + alu_b;
            ALU_SUB: result = op_a - alu_b;
            ALU_AND: result = op_a & alu_b;
            ALU_OR:  result = op_a | alu_b;
            ALU_XOR: result = op_a ^ alu_b;
            ALU_SLT: result = {{(WORD_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_mem_reg_write <= 1'b0;
            o_mem_mem_read  <= 1'b0;
            o_mem_mem_write <= 1'b0;
            o_mem_halt      <= 1'b0;
        end else if (i_run) begin
            o_mem_reg_write <= i_ex_reg_write;
            o_mem_mem_read  <= i_ex_mem_read;
            o_mem_mem_write <= i_ex_mem_write;
            o_mem_halt      <= i_ex_halt;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_mem_result     <= result;
            o_mem_store_data <= op_b;  // SW data after forwarding
            o_mem_dest       <= i_ex_dest;
        end
    end

    // Load-use stall in decode keeps a consumer away from a load in EX/MEM
    a_no_fwd_from_load: assert property (@(posedge i_clock) disable iff (i_reset)
        (mem_hit_a || mem_hit_b) && (i_ex_reg_write || i_ex_mem_write) |-> !o_mem_mem_read);

endmodule

// ==== memory_stage.sv ====
module memory_stage #(
    parameter int DM_ADDR_BITS = 5
) (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_run,
    input  mips_pkg::word_t     i_mem_result,
    input  mips_pkg::word_t     i_mem_store_data,
    input  mips_pkg::reg_addr_t i_mem_dest,
    input  logic                i_mem_reg_write,
    input  logic                i_mem_mem_read,
    input  logic                i_mem_mem_write,
    input  logic                i_mem_halt,
    output logic                o_wb_we,
    output mips_pkg::reg_addr_t o_wb_reg,
    output mips_pkg::word_t     o_wb_data,
    output logic                o_wb_halt
);
    import mips_pkg::*;

    word_t                   dmem [2**DM_ADDR_BITS];
    logic [DM_ADDR_BITS-1:0] dm_addr;
    word_t                   wb_sel;

    assign dm_addr = i_mem_result[DM_ADDR_BITS+1:2];  // Drop byte offset
    assign wb_sel  = i_mem_mem_read ? dmem[dm_addr] : i_mem_result;

    always_ff @(posedge i_clock) begin
        if (i_run && i_mem_mem_write) begin
            dmem[dm_addr] <= i_mem_store_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb_we   <= 1'b0;
            o_wb_halt <= 1'b0;
        end else if (i_run) begin
            o_wb_we   <= i_mem_reg_write;
            o_wb_halt <= i_mem_halt;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_wb_reg  <= i_mem_dest;
            o_wb_data <= wb_sel;
        end
    end

    a_word_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_mem_mem_read || i_mem_mem_write) |-> i_mem_result[1:0] == 2'b00);

endmodule

// ==== mips_top.sv ====
module mips_top #(
    parameter int DM_ADDR_BITS = 5
) (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_load_req,
    input  mips_pkg::im_addr_t  i_load_addr,
    input  mips_pkg::word_t     i_load_data,
    output logic                o_load_ack,
    input  logic                i_start,
    input  logic                i_rd_req,
    input  mips_pkg::reg_addr_t i_rd_addr,
    output logic                o_rd_ack,
    output mips_pkg::word_t     o_rd_data,
    output logic                o_halt
);
    import mips_pkg::*;

    logic      run, im_we, stall;
    word_t     instr;

    // ID/EX
    alu_op_t   ex_alu_op;
    word_t     ex_a, ex_b, ex_imm;
    reg_addr_t ex_rs, ex_rt, ex_dest;
    logic      ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write, ex_halt;

    // EX/MEM
    word_t     mem_result, mem_store_data;
    reg_addr_t mem_dest;
    logic      mem_reg_write, mem_mem_read, mem_mem_write, mem_halt;

    // MEM/WB
    logic      wb_we, wb_halt;
    reg_addr_t wb_reg;
    word_t     wb_data;

    debug_ctrl u_debug_ctrl (
        .i_clock, .i_reset,
        .i_load_req, .o_load_ack, .i_start, .i_rd_req, .o_rd_ack,
        .i_wb_halt(wb_halt), .o_halt, .o_run(run), .o_im_we(im_we)
    );

    fetch_stage u_fetch (
        .i_clock, .i_reset, .i_run(run), .i_stall(stall),
        .i_im_we(im_we), .i_im_waddr(i_load_addr), .i_im_wdata(i_load_data),
        .o_instr(instr)
    );

    decode_stage u_decode (
        .i_clock, .i_reset, .i_run(run), .i_instr(instr),
        .i_wb_we(wb_we), .i_wb_reg(wb_reg), .i_wb_data(wb_data),
        .i_dbg_raddr(i_rd_addr), .o_dbg_rdata(o_rd_data), .o_stall(stall),
        .o_ex_alu_op(ex_alu_op), .o_ex_a(ex_a), .o_ex_b(ex_b), .o_ex_imm(ex_imm),
        .o_ex_use_imm(ex_use_imm), .o_ex_rs(ex_rs), .o_ex_rt(ex_rt), .o_ex_dest(ex_dest),
        .o_ex_reg_write(ex_reg_write), .o_ex_mem_read(ex_mem_read),
        .o_ex_mem_write(ex_mem_write), .o_ex_halt(ex_halt)
    );

    execute_stage u_execute (
        .i_clock, .i_reset, .i_run(run),
        .i_ex_alu_op(ex_alu_op), .i_ex_a(ex_a), .i_ex_b(ex_b), .i_ex_imm(ex_imm),
        .i_ex_use_imm(ex_use_imm), .i_ex_rs(ex_rs), .i_ex_rt(ex_rt), .i_ex_dest(ex_dest),
        .i_ex_reg_write(ex_reg_write), .i_ex_mem_read(ex_mem_read),
        .i_ex_mem_write(ex_mem_write), .i_ex_halt(ex_halt),
        .i_wb_we(wb_we), .i_wb_reg(wb_reg), .i_wb_data(wb_data),
        .o_mem_result(mem_result), .o_mem_store_data(mem_store_data), .o_mem_dest(mem_dest),
        .o_mem_reg_write(mem_reg_write), .o_mem_mem_read(mem_mem_read),
        .o_mem_mem_write(mem_mem_write), .o_mem_halt(mem_halt)
    );

    memory_stage #(
        .DM_ADDR_BITS(DM_ADDR_BITS)
    ) u_memory (
        .i_clock, .i_reset, .i_run(run),
        .i_mem_result(mem_result), .i_mem_store_data(mem_store_data), .i_mem_dest(mem_dest),
        .i_mem_reg_write(mem_reg_write), .i_mem_mem_read(mem_mem_read),
        .i_mem_mem_write(mem_mem_write), .i_mem_halt(mem_halt),
        .o_wb_we(wb_we), .o_wb_reg(wb_reg), .o_wb_data(wb_data), .o_wb_halt(wb_halt)
    );

endmodule

// ==== tb_programs.svh ====
localparam int NUM_TESTS  = 4;
localparam int MAX_WORDS  = 16;  // Unused words stay zero, which is a no-op
localparam int MAX_CHECKS = 8;

string     test_name [NUM_TESTS];
word_t     prog      [NUM_TESTS][MAX_WORDS];
int        prog_len  [NUM_TESTS];
reg_addr_t chk_reg   [NUM_TESTS][MAX_CHECKS];
word_t     chk_val   [NUM_TESTS][MAX_CHECKS];
int        chk_count [NUM_TESTS];

task automatic add_instr(int t, word_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t] = prog_len[t] + 1;
endtask

task automatic add_check(int t, reg_addr_t r, word_t v);
    chk_reg[t][chk_count[t]] = r;
    chk_val[t][chk_count[t]] = v;
    chk_count[t] = chk_count[t] + 1;
endtask

task automatic build_programs();
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t]  = 0;
        chk_count[t] = 0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            prog[t][i] = '0;
        end
    end

    // Dependent R-type chain, every operand forwarded
    test_name[0] = "rtype_forward";
    add_instr(0, itype_word(OP_ADDI, 1, 0, 16'h0005));
    add_instr(0, itype_word(OP_ADDI, 2, 0, 16'hfffd));  // -3
    add_instr(0, rtype_word(FN_ADDU, 3, 1, 2));
    add_instr(0, rtype_word(FN_SUBU, 4, 3, 1));
    add_instr(0, rtype_word(FN_AND, 5, 4, 1));
    add_instr(0, rtype_word(FN_OR, 6, 5, 2));
    add_instr(0, rtype_word(FN_XOR, 7, 6, 1));
    add_instr(0, rtype_word(FN_SLT, 8, 2, 1));
    add_instr(0, rtype_word(FN_SLT, 9, 1, 2));
    add_instr(0, itype_word(OP_HALT, 0, 0, 16'h0000));
    add_check(0, 3, 32'h0000_0002);
    add_check(0, 4, 32'hffff_fffd);
    add_check(0, 5, 32'h0000_0005);
    add_check(0, 6, 32'hffff_fffd);
    add_check(0, 7, 32'hffff_fff8);
    add_check(0, 8, 32'h0000_0001);
    add_check(0, 9, 32'h0000_0000);

    test_name[1] = "immediates";
    add_instr(1, itype_word(OP_ADDI, 1, 0, 16'hfff0));  // -16
    add_instr(1, itype_word(OP_ANDI, 2, 1, 16'h8f0f));
    add_instr(1, itype_word(OP_ORI, 3, 0, 16'h8001));
    add_instr(1, itype_word(OP_ORI, 4, 1, 16'h800f));
    add_instr(1, itype_word(OP_ADDI, 5, 1, 16'h7fff));
    add_instr(1, itype_word(OP_ADDI, 6, 0, 16'h0011));
    add_instr(1, itype_word(OP_ADDI, 6, 0, 16'h0022));
    add_instr(1, itype_word(OP_ADDI, 7, 6, 16'h0001));  // Two writes of r6 in flight
    add_instr(1, itype_word(OP_HALT, 0, 0, 16'h0000));
    add_check(1, 1, 32'hffff_fff0);
    add_check(1, 2, 32'h0000_8f00);
    add_check(1, 3, 32'h0000_8001);
    add_check(1, 4, 32'hffff_ffff);
    add_check(1, 5, 32'h0000_7fef);
    add_check(1, 6, 32'h0000_0022);
    add_check(1, 7, 32'h0000_0023);

    test_name[2] = "load_use";
    add_instr(2, itype_word(OP_ADDI, 1, 0, 16'h1234));
    add_instr(2, itype_word(OP_ADDI, 2, 0, 16'h0008));
    add_instr(2, itype_word(OP_SW, 1, 2, 16'h0004));    // Word 3
    add_instr(2, itype_word(OP_LW, 3, 2, 16'h0004));
    add_instr(2, rtype_word(FN_ADDU, 4, 3, 3));         // Stalls on rs and rt
    add_instr(2, itype_word(OP_LW, 5, 2, 16'h0004));
    add_instr(2, itype_word(OP_ADDI, 6, 5, 16'h0001));
    add_instr(2, itype_word(OP_HALT, 0, 0, 16'h0000));
    add_check(2, 3, 32'h0000_1234);
    add_check(2, 4, 32'h0000_2468);
    add_check(2, 5, 32'h0000_1234);
    add_check(2, 6, 32'h0000_1235);

    // Words after HALT must never write
    test_name[3] = "halt_r0";
    add_instr(3, itype_word(OP_ADDI, 0, 0, 16'h0007));
    add_instr(3, itype_word(OP_ADDI, 1, 0, 16'h0009));
    add_instr(3, itype_word(OP_HALT, 0, 0, 16'h0000));
    add_instr(3, itype_word(OP_ADDI, 2, 0, 16'h0001));
    add_instr(3, itype_word(OP_ADDI, 3, 0, 16'h0002));
    add_check(3, 0, 32'h0000_0000);
    add_check(3, 1, 32'h0000_0009);
    add_check(3, 2, 32'h0000_0000);
    add_check(3, 3, 32'h0000_0000);
endtask

// ==== tb_mips.sv ====
module tb_mips;
    import mips_pkg::*;

    localparam int          TIMEOUT       = 200;  // Cycles for any single wait
    localparam int          NO_ACK_CYCLES = 20;
    localparam int unsigned SEED          = 32'h3c275a3d;

    logic      i_clock;
    logic      i_reset;
    logic      i_load_req;
    im_addr_t  i_load_addr;
    word_t     i_load_data;
    logic      o_load_ack;
    logic      i_start;
    logic      i_rd_req;
    reg_addr_t i_rd_addr;
    logic      o_rd_ack;
    word_t     o_rd_data;
    logic      o_halt;

    mips_top #(
        .DM_ADDR_BITS(5)
    ) i_dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    function automatic word_t rtype_word(funct_t fn, reg_addr_t rd, reg_addr_t rs,
                                         reg_addr_t rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_addr_t rt, reg_addr_t rs, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    `include "tb_programs.svh"

    // Inputs change and outputs are sampled just after the rising edge
    task automatic step(int n);
        repeat (n) @(posedge i_clock);
        #1;
    endtask

    task automatic stop_with_error(string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("CHECK FAILED %s expected %b actual %b",
                                      name, expected, actual));
        end
    endtask

    task automatic load_word(im_addr_t addr, word_t data);
        int n;
        n = 0;
        i_load_addr = addr;
        i_load_data = data;
        i_load_req  = 1'b1;
        while (!o_load_ack) begin
            step(1);
            n++;
            if (n > TIMEOUT) begin
                stop_with_error($sformatf("load ack never rose for word %0d", addr));
            end
        end
        step(1);
        check_bit("load ack held while req high", 1'b1, o_load_ack);
        i_load_req = 1'b0;
        n = 0;
        while (o_load_ack) begin
            step(1);
            n++;
            if (n > TIMEOUT) begin
                stop_with_error($sformatf("load ack never fell for word %0d", addr));
            end
        end
    endtask

    task automatic read_reg(reg_addr_t addr, output word_t data);
        int n;
        n = 0;
        i_rd_addr = addr;
        i_rd_req  = 1'b1;
        while (!o_rd_ack) begin
            step(1);
            n++;
            if (n > TIMEOUT) begin
                stop_with_error($sformatf("read ack never rose for r%0d", addr));
            end
        end
        data     = o_rd_data;
        i_rd_req = 1'b0;
        n = 0;
        while (o_rd_ack) begin
            step(1);
            n++;
            if (n > TIMEOUT) begin
                stop_with_error($sformatf("read ack never fell for r%0d", addr));
            end
        end
    endtask

    task automatic run_test(int t);
        word_t data;
        int    n;
        i_reset = 1'b1;
        step(8);
        i_reset = 1'b0;
        step(1);
        check_bit({test_name[t], " load ack after reset"}, 1'b0, o_load_ack);
        check_bit({test_name[t], " read ack after reset"}, 1'b0, o_rd_ack);
        check_bit({test_name[t], " halt after reset"}, 1'b0, o_halt);

        // Registers read zero before the program runs
        read_reg(5'd1, data);
        check_word({test_name[t], " r1 before start"}, '0, data);

        for (int i = 0; i < MAX_WORDS; i++) begin
            step(1 + ($urandom % 4));
            load_word(i, prog[t][i]);
        end
        step(1 + ($urandom % 4));
        i_start = 1'b1;
        step(1);
        i_start = 1'b0;
        n = 0;
        while (!o_halt) begin
            step(1);
            n++;
            if (n > TIMEOUT) begin
                stop_with_error({test_name[t], " o_halt never rose"});
            end
        end

        for (int c = 0; c < chk_count[t]; c++) begin
            step(1 + ($urandom % 4));
            read_reg(chk_reg[t][c], data);
            check_word($sformatf("%s r%0d", test_name[t], chk_reg[t][c]),
                       chk_val[t][c], data);
        end

        // Loading is closed once halted
        i_load_req = 1'b1;
        for (int i = 0; i < NO_ACK_CYCLES; i++) begin
            step(1);
            check_bit({test_name[t], " load ack after halt"}, 1'b0, o_load_ack);
        end
        i_load_req = 1'b0;
        step(1);
    endtask

    initial begin
        i_reset     = 1'b1;
        i_load_req  = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_start     = 1'b0;
        i_rd_req    = 1'b0;
        i_rd_addr   = '0;
        void'($urandom(SEED));
        build_programs();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
mips_pkg.sv
reg_file.sv
debug_ctrl.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_top.sv
tb_mips.sv
